// File: hw/fp80_pkg.sv
// Shared FP80 field widths, constants, struct types, operation codes and class checks for the bit-op unit
`default_nettype none

package fp80_pkg;

    // ====================
    // Format constants
    // ====================

    // Extended precision layout: sign, 15-bit exponent, 64-bit significand
    localparam int EXP_W  = 15;
    localparam int MANT_W = 64;

    // Biased exponent of 1.0
    localparam int EXP_BIAS = 16383;

    // All-ones exponent marks infinity and NaN
    localparam logic [EXP_W-1:0] EXP_MAX = '1;

    // Explicit integer bit alone, the infinity significand
    localparam logic [MANT_W-1:0] MANT_INT_BIT = {1'b1, {(MANT_W - 1){1'b0}}};

    // ====================
    // Types
    // ====================

    // One FP80 value, 80 bits with the sign on top
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [MANT_W-1:0] mantissa;
    } fp80_t;

    // Operation codes, numbered as in the full arithmetic unit
    typedef enum logic [4:0] {
        OP_INT16_TO_FP = 5'd4,
        OP_INT32_TO_FP = 5'd5,
        OP_FXTRACT     = 5'd23,
        OP_FSCALE      = 5'd24
    } op_e;

    // Registered result bundle
    typedef struct packed {
        fp80_t primary;
        fp80_t secondary;
        // Secondary holds a value, only for FXTRACT
        logic  has_secondary;
        logic  flag_denormal;
    } bitops_out_t;

    // FXTRACT result pair
    typedef struct packed {
        fp80_t significand;
        fp80_t exponent;
    } fp80_pair_t;

    // ====================
    // Classification
    // ====================

    // Zero of either sign
    function automatic logic is_zero(input fp80_t value);
        return (value.exponent == '0) && (value.mantissa == '0);
    endfunction

    // Infinity needs exactly the integer bit set
    function automatic logic is_inf(input fp80_t value);
        return (value.exponent == EXP_MAX) && (value.mantissa == MANT_INT_BIT);
    endfunction

    // Any other significand with the max exponent counts as NaN
    function automatic logic is_nan(input fp80_t value);
        return (value.exponent == EXP_MAX) && (value.mantissa != MANT_INT_BIT);
    endfunction

    // Zero exponent, nonzero significand
    function automatic logic is_denormal(input fp80_t value);
        return (value.exponent == '0) && (value.mantissa != '0);
    endfunction

    // Signed infinity
    function automatic fp80_t make_inf(input logic sign);
        return '{sign: sign, exponent: EXP_MAX, mantissa: MANT_INT_BIT};
    endfunction

    // Signed zero
    function automatic fp80_t make_zero(input logic sign);
        return '{sign: sign, exponent: '0, mantissa: '0};
    endfunction

endpackage

`default_nettype wire

// File: hw/fp80_int_to_fp.sv
// Exact conversion of a signed integer of any width up to 64 bits into FP80, purely combinational
`default_nettype none

module fp80_int_to_fp #(
    parameter int INT_WIDTH = 16
) (
    input  wire logic signed [INT_WIDTH-1:0] value,
    output fp80_pkg::fp80_t                  fp
);

    import fp80_pkg::*;

    // Enough bits to name every position of the integer
    localparam int POS_W = $clog2(INT_WIDTH);

    // Absolute value, most negative input maps to 2^(INT_WIDTH-1)
    logic [INT_WIDTH-1:0] magnitude;

    // Position of the leading one
    logic [POS_W-1:0] lead_pos;

    // Magnitude widened to the significand
    logic [MANT_W-1:0] wide_mag;

    // ====================
    // Magnitude
    // ====================

    // Two's complement negate when the sign bit is set
    always_comb begin
        if (value[INT_WIDTH-1]) begin
            magnitude = ~$unsigned(value) + 1'b1;
        end else begin
            magnitude = $unsigned(value);
        end
    end

    // ====================
    // Leading one search
    // ====================

    // Upward scan, so the highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < INT_WIDTH; i++) begin
            if (magnitude[i]) begin
                lead_pos = POS_W'(i);
            end
        end
    end

    assign wide_mag = MANT_W'(magnitude);

    // ====================
    // Pack
    // ====================

    always_comb begin
        if (magnitude == '0) begin
            // Integer zero is always positive zero
            fp = make_zero(1'b0);
        end else begin
            fp.sign     = value[INT_WIDTH-1];
            // Unbiased exponent equals the leading one position
            fp.exponent = EXP_W'(EXP_BIAS) + EXP_W'(lead_pos);
            // Leading one moves up to the explicit integer bit
            fp.mantissa = wide_mag << ((MANT_W - 1) - int'(lead_pos));
        end
    end

endmodule

`default_nettype wire

// File: hw/fp80_extract.sv
// FXTRACT datapath: splits an FP80 value into significand and unbiased exponent, both as FP80
`default_nettype none

module fp80_extract (
    input  fp80_pkg::fp80_t      operand,
    output fp80_pkg::fp80_pair_t parts
);

    import fp80_pkg::*;

    // Unbiased exponent, covers -16383 to +16384
    logic signed [15:0] true_exp;

    // Unbiased exponent as an FP80 value
    fp80_t exp_fp;

    // ====================
    // Exponent conversion
    // ====================

    // Denormals fall through with exponent zero, as on the reference unit
    assign true_exp = signed'(16'(operand.exponent) - 16'(EXP_BIAS));

    // 16 bits always suffice for the exponent range
    fp80_int_to_fp #(
        .INT_WIDTH(16)
    ) u_exp_conv (
        .value(true_exp),
        .fp   (exp_fp)
    );

    // ====================
    // Special cases
    // ====================

    always_comb begin
        // Defaults serve the finite nonzero case
        parts.significand = operand;
        parts.exponent    = exp_fp;

        if (is_nan(operand)) begin
            // NaN goes to both results unchanged
            parts.exponent = operand;
        end else if (is_zero(operand)) begin
            // log2 of zero
            parts.exponent = make_inf(1'b1);
        end else if (is_inf(operand)) begin
            parts.exponent = make_inf(1'b0);
        end else begin
            // Significand rebased into [1, 2), sign kept
            parts.significand.exponent = EXP_W'(EXP_BIAS);
        end
    end

endmodule

`default_nettype wire

// File: hw/fp80_scale.sv
// FSCALE datapath: adds the truncated integer of operand b to the exponent of operand a
`default_nettype none

module fp80_scale (
    input  fp80_pkg::fp80_t operand_a,
    input  fp80_pkg::fp80_t operand_b,
    output fp80_pkg::fp80_t scaled
);

    import fp80_pkg::*;

    // b exponent with the bias removed, meaningful only when b >= 1
    logic [EXP_W-1:0] b_unbiased;

    // Integer part of |b|, at most 16 bits within the exact range
    logic [15:0] b_int_part;

    // Signed scale after truncation toward zero
    logic signed [31:0] scale_int;

    // Biased exponent of a after scaling
    logic signed [31:0] new_exp;

    // ====================
    // Scale integer
    // ====================

    assign b_unbiased = operand_b.exponent - EXP_W'(EXP_BIAS);

    // Drop the fraction bits below the binary point
    assign b_int_part = 16'(operand_b.mantissa >> ((MANT_W - 1) - int'(b_unbiased[3:0])));

    always_comb begin
        if (operand_b.exponent < EXP_W'(EXP_BIAS)) begin
            // |b| < 1 truncates to zero
            scale_int = '0;
        end else if (b_unbiased < EXP_W'(16)) begin
            if (operand_b.sign) begin
                scale_int = -signed'(32'(b_int_part));
            end else begin
                scale_int = signed'(32'(b_int_part));
            end
        end else begin
            // Past any finite exponent span, clamp
            scale_int = operand_b.sign ? -32'sd16384 : 32'sd16384;
        end
    end

    assign new_exp = signed'(32'(operand_a.exponent)) + scale_int;

    // ====================
    // Result selection
    // ====================

    always_comb begin
        if (is_nan(operand_a) || is_nan(operand_b)) begin
            // First NaN wins
            scaled = is_nan(operand_a) ? operand_a : operand_b;
        end else if (is_zero(operand_a) || is_inf(operand_a)) begin
            scaled = operand_a;
        end else if (is_inf(operand_b)) begin
            // 2^-inf is zero, 2^+inf is infinity
            if (operand_b.sign) begin
                scaled = make_zero(operand_a.sign);
            end else begin
                scaled = make_inf(operand_a.sign);
            end
        end else if (new_exp > 32'sd32766) begin
            // Overflow
            scaled = make_inf(operand_a.sign);
        end else if (new_exp < 32'sd1) begin
            // Underflow judged on the biased exponent, no denormal output
            scaled = make_zero(operand_a.sign);
        end else begin
            scaled.sign     = operand_a.sign;
            scaled.exponent = new_exp[EXP_W-1:0];
            scaled.mantissa = operand_a.mantissa;
        end
    end

endmodule

`default_nettype wire

// File: hw/fp80_result_stage.sv
// Output stage: decodes the operation, converts integers, flags denormals, registers the result
`default_nettype none

module fp80_result_stage (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               enable,
    input  fp80_pkg::op_e           operation,
    input  fp80_pkg::fp80_t         operand_a,
    input  fp80_pkg::fp80_t         operand_b,
    input  wire logic signed [31:0] int_in,
    input  fp80_pkg::fp80_pair_t    parts,
    input  fp80_pkg::fp80_t         scaled,
    output logic                    done,
    output fp80_pkg::bitops_out_t   out
);

    import fp80_pkg::*;

    // Integer fed to the converter
    logic signed [31:0] conv_in;

    // Conversion result
    fp80_t conv_fp;

    // Either operand denormal
    logic denorm_in;

    // Operation code is one of ours
    logic accept;

    // Result about to be registered
    bitops_out_t next_out;

    // ====================
    // Integer conversion
    // ====================

    // 16-bit mode reads the low half of int_in, sign extended
    assign conv_in = (operation == OP_INT16_TO_FP) ? {{16{int_in[15]}}, int_in[15:0]} : int_in;

    fp80_int_to_fp #(
        .INT_WIDTH(32)
    ) u_int_conv (
        .value(conv_in),
        .fp   (conv_fp)
    );

    assign denorm_in = is_denormal(operand_a) || is_denormal(operand_b);

    // ====================
    // Operation decode
    // ====================

    always_comb begin
        accept   = 1'b1;
        next_out = '0;
        case (operation)
            OP_INT16_TO_FP, OP_INT32_TO_FP: begin
                next_out.primary = conv_fp;
            end
            OP_FXTRACT: begin
                next_out.primary       = parts.significand;
                next_out.secondary     = parts.exponent;
                next_out.has_secondary = 1'b1;
                next_out.flag_denormal = denorm_in;
            end
            OP_FSCALE: begin
                next_out.primary       = scaled;
                next_out.flag_denormal = denorm_in;
            end
            default: begin
                // Unknown code, nothing captured
                accept = 1'b0;
            end
        endcase
    end

    // ====================
    // Output register
    // ====================

    // Single cycle latency, out holds until the next accepted operation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
            out  <= '0;
        end else begin
            done <= enable && accept;
            if (enable && accept) begin
                out <= next_out;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/fp80_bitops_unit.sv
// Top level of the FP80 bit-op unit: FXTRACT and FSCALE datapaths feeding the result stage
`default_nettype none

module fp80_bitops_unit (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               enable,
    input  fp80_pkg::op_e           operation,
    input  fp80_pkg::fp80_t         operand_a,
    input  fp80_pkg::fp80_t         operand_b,
    input  wire logic signed [31:0] int_in,
    output logic                    done,
    output fp80_pkg::bitops_out_t   out
);

    import fp80_pkg::*;

    // FXTRACT significand and exponent
    fp80_pair_t parts;

    // FSCALE result
    fp80_t scaled;

    // ====================
    // Datapaths
    // ====================

    // Both run every cycle, the result stage picks one
    fp80_extract u_extract (
        .operand(operand_a),
        .parts  (parts)
    );

    fp80_scale u_scale (
        .operand_a(operand_a),
        .operand_b(operand_b),
        .scaled   (scaled)
    );

    // ====================
    // Output stage
    // ====================

    fp80_result_stage u_result (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .operation(operation),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .int_in   (int_in),
        .parts    (parts),
        .scaled   (scaled),
        .done     (done),
        .out      (out)
    );

endmodule

`default_nettype wire

// File: include/fp80_model.svh
// Reference model of the four bit-op operations and the denormal flag that the testbench includes
`ifndef FP80_MODEL_SVH
`define FP80_MODEL_SVH

// Value classes of the extended format
localparam int CLASS_FINITE = 0;
localparam int CLASS_ZERO   = 1;
localparam int CLASS_INF    = 2;
localparam int CLASS_NAN    = 3;

// Max exponent holds infinity with only the integer bit set and NaN otherwise
function automatic int classify(input fp80_pkg::fp80_t x);
    if (x.exponent == 15'h7FFF) begin
        return (x.mantissa == 64'h8000_0000_0000_0000) ? CLASS_INF : CLASS_NAN;
    end
    if ((x.exponent == 15'd0) && (x.mantissa == 64'd0)) begin
        return CLASS_ZERO;
    end
    return CLASS_FINITE;
endfunction

// Signed infinity when infinite is set and signed zero otherwise
function automatic fp80_pkg::fp80_t zero_or_inf(input logic sign, input logic infinite);
    fp80_pkg::fp80_t r;
    r      = '0;
    r.sign = sign;
    if (infinite) begin
        r.exponent = 15'h7FFF;
        r.mantissa = 64'h8000_0000_0000_0000;
    end
    return r;
endfunction

// Exact integer to FP80 for any value within 32 bits
function automatic fp80_pkg::fp80_t exact_int_to_fp(input longint value);
    fp80_pkg::fp80_t  r;
    longint unsigned  mag;
    int               pos;
    r   = '0;
    pos = 0;
    if (value != 0) begin
        mag = (value < 0) ? -value : value;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) pos = i;
        end
        r.sign     = (value < 0);
        r.exponent = 15'(16383 + pos);
        r.mantissa = mag << (63 - pos);
    end
    return r;
endfunction

// FSCALE by the truncate-and-clamp rule
function automatic fp80_pkg::fp80_t scale_by_rule(input fp80_pkg::fp80_t a,
                                                  input fp80_pkg::fp80_t b);
    int scale;
    int new_exp;
    int a_class;
    int b_class;
    a_class = classify(a);
    b_class = classify(b);
    if (b.exponent < 16383) scale = 0;
    else if (b.exponent <= 16398) scale = int'(b.mantissa >> (63 - (b.exponent - 16383)));
    else scale = 16384;
    if (b.sign) scale = -scale;
    new_exp = int'(a.exponent) + scale;
    if (a_class == CLASS_NAN) return a;
    if (b_class == CLASS_NAN) return b;
    if (a_class == CLASS_ZERO || a_class == CLASS_INF) return a;
    // Infinite scale gives zero for -inf and infinity for +inf
    if (b_class == CLASS_INF) return zero_or_inf(a.sign, !b.sign);
    if (new_exp > 32766) return zero_or_inf(a.sign, 1'b1);
    if (new_exp < 1) return zero_or_inf(a.sign, 1'b0);
    return '{sign: a.sign, exponent: 15'(new_exp), mantissa: a.mantissa};
endfunction

// Full expected output bundle for one accepted operation
function automatic fp80_pkg::bitops_out_t expected_out(input fp80_pkg::op_e op,
                                                       input fp80_pkg::fp80_t a,
                                                       input fp80_pkg::fp80_t b,
                                                       input logic signed [31:0] int_in);
    fp80_pkg::bitops_out_t e;
    logic                  denorm;
    longint                low_half;
    int                    a_class;
    a_class  = classify(a);
    e        = '0;
    // Zero exponent on a value that is not a zero
    denorm   = ((a.exponent == 15'd0) && (a_class != CLASS_ZERO)) ||
               ((b.exponent == 15'd0) && (classify(b) != CLASS_ZERO));
    // Low 16 bits read as a two's complement value
    low_half = longint'(int_in[15:0]) - (int_in[15] ? 65536 : 0);
    case (op)
        fp80_pkg::OP_INT16_TO_FP: e.primary = exact_int_to_fp(low_half);
        fp80_pkg::OP_INT32_TO_FP: e.primary = exact_int_to_fp(longint'(int_in));
        fp80_pkg::OP_FXTRACT: begin
            e.has_secondary = 1'b1;
            e.flag_denormal = denorm;
            e.primary       = a;
            if (a_class == CLASS_NAN) e.secondary = a;
            else if (a_class == CLASS_ZERO) e.secondary = zero_or_inf(1'b1, 1'b1);
            else if (a_class == CLASS_INF) e.secondary = zero_or_inf(1'b0, 1'b1);
            else begin
                e.primary.exponent = 15'd16383;
                e.secondary        = exact_int_to_fp(longint'(a.exponent) - 16383);
            end
        end
        fp80_pkg::OP_FSCALE: begin
            e.primary       = scale_by_rule(a, b);
            e.flag_denormal = denorm;
        end
        default: e = '0;
    endcase
    return e;
endfunction

`endif

// File: bench/fp80_bitops_tb.sv
// Self-checking testbench of the FP80 bit-op unit that run_sim.sh builds from the file list and runs
`default_nettype none

module fp80_bitops_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import fp80_pkg::*;

    `include "fp80_model.svh"

    // Cycles to wait for done before giving up
    localparam int TIMEOUT = 20;

    // Directed FSCALE operands
    localparam fp80_t A_MID  = '{sign: 1'b0, exponent: 15'd16400, mantissa: 64'hC000_0000_0000_0000};
    localparam fp80_t A_HIGH = '{sign: 1'b1, exponent: 15'd32760, mantissa: 64'h8000_0000_0000_0001};
    localparam fp80_t A_LOW  = '{sign: 1'b0, exponent: 15'd5, mantissa: 64'hF000_0000_0000_0000};
    localparam fp80_t A_DEN  = '{sign: 1'b1, exponent: 15'd0, mantissa: 64'h0000_0000_0000_1234};
    localparam fp80_t A_NAN  = '{sign: 1'b0, exponent: 15'h7FFF, mantissa: 64'hC000_0000_0000_0001};
    localparam fp80_t B_NAN  = '{sign: 1'b1, exponent: 15'h7FFF, mantissa: 64'hC000_0000_0000_0002};
    localparam fp80_t TEN    = '{sign: 1'b0, exponent: 15'd16386, mantissa: 64'hA000_0000_0000_0000};
    localparam fp80_t M_TEN  = '{sign: 1'b1, exponent: 15'd16386, mantissa: 64'hA000_0000_0000_0000};
    // 2.75 and -2.75 both truncate to magnitude 2
    localparam fp80_t FRAC   = '{sign: 1'b0, exponent: 15'd16384, mantissa: 64'hB000_0000_0000_0000};
    localparam fp80_t M_FRAC = '{sign: 1'b1, exponent: 15'd16384, mantissa: 64'hB000_0000_0000_0000};
    // Far beyond 2^15 so the scale saturates
    localparam fp80_t HUGE   = '{sign: 1'b0, exponent: 15'd16420, mantissa: 64'h8000_0000_0000_0000};
    localparam fp80_t M_HUGE = '{sign: 1'b1, exponent: 15'd16420, mantissa: 64'h8000_0000_0000_0000};

    logic               clk;
    logic               arst_n;
    logic               enable;
    op_e                operation;
    fp80_t              operand_a;
    fp80_t              operand_b;
    logic signed [31:0] int_in;
    logic               done;
    bitops_out_t        out;

    int          seed;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    bitops_out_t expect_q[$];
    bitops_out_t held;

    // Edge cases for the integer paths
    logic signed [31:0] fixed_ints [6] = '{32'sd0, -32'sd1, 32'sh8000_0000, 32'sh0000_8000,
                                           32'sh7FFF_FFFF, 32'sh0001_0000};

    fp80_bitops_unit UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .operation(operation),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .int_in   (int_in),
        .done     (done),
        .out      (out)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ====================
    // Stimulus helpers
    // ====================

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Operand biased toward special classes and the FSCALE exponent limits
    function automatic fp80_t random_fp();
        fp80_t v;
        v.sign     = (rand_below(2) == 1);
        v.mantissa = {1'b1, 31'($random(seed)), $random(seed)};
        v.exponent = 15'(1 + rand_below(32766));
        case (rand_below(8))
            0: v = make_zero(v.sign);
            1: v = make_inf(v.sign);
            2: begin
                // Quiet bit set keeps it off the infinity pattern
                v.exponent    = EXP_MAX;
                v.mantissa[62] = 1'b1;
            end
            3: begin
                v.exponent     = '0;
                v.mantissa[63] = 1'b0;
                v.mantissa[0]  = 1'b1;
            end
            4: v.exponent = 15'(32766 - rand_below(40));
            5: v.exponent = 15'(1 + rand_below(40));
            // Around the truncation and saturation range of the scale
            6: v.exponent = 15'(16378 + rand_below(25));
            default: ;
        endcase
        return v;
    endfunction

    function automatic logic signed [31:0] random_int();
        case (rand_below(5))
            0: return '0;
            1: return -32'sd1;
            2: return (rand_below(2) == 1) ? 32'sh8000_0000 : 32'sh0000_8000;
            3: return 32'sd1 <<< rand_below(32);
            default: return $random(seed);
        endcase
    endfunction

    // ====================
    // Checking
    // ====================

    task automatic check_value(input string what, input logic [161:0] got,
                               input logic [161:0] exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // One operation issued on a falling edge and checked on the falling edge that shows done
    task automatic run_single(input op_e op, input fp80_t a, input fp80_t b,
                              input logic signed [31:0] i);
        int waited;
        expect_q.push_back(expected_out(op, a, b, i));
        operation = op;
        operand_a = a;
        operand_b = b;
        int_in    = i;
        enable    = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        waited = 0;
        while (!done && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            test_errors++;
            $display("No done pulse within %0d cycles for operation code %0d", TIMEOUT, op);
            void'(expect_q.pop_front());
        end else begin
            check_value("out", out, expect_q.pop_front());
        end
    endtask

    // Enable held high with every cycle checked against the previous operation
    task automatic run_back_to_back(input int count);
        op_e op;
        for (int n = 0; n < count; n++) begin
            case (rand_below(4))
                0: op = OP_INT16_TO_FP;
                1: op = OP_INT32_TO_FP;
                2: op = OP_FXTRACT;
                default: op = OP_FSCALE;
            endcase
            operation = op;
            operand_a = random_fp();
            operand_b = random_fp();
            int_in    = random_int();
            enable    = 1'b1;
            expect_q.push_back(expected_out(op, operand_a, operand_b, int_in));
            @(negedge clk);
            check_value("done back to back", 162'(done), 162'(1));
            check_value("out back to back", out, expect_q.pop_front());
        end
        enable = 1'b0;
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        seed         = 77456;
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        clk          = 1'b0;
        arst_n       = 1'b0;
        enable       = 1'b0;
        operation    = OP_INT16_TO_FP;
        operand_a    = '0;
        operand_b    = '0;
        int_in       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_value("done after reset", 162'(done), '0);
        check_value("out after reset", out, '0);
        for (int n = 0; n < 6; n++) begin
            @(negedge clk);
            check_value("done while idle", 162'(done), '0);
        end
        end_test("reset and idle");

        for (int n = 0; n < 6; n++) begin
            run_single(OP_INT16_TO_FP, '0, '0, fixed_ints[n]);
            run_single(OP_INT32_TO_FP, '0, '0, fixed_ints[n]);
        end
        for (int n = 0; n < 300; n++) begin
            run_single((rand_below(2) == 1) ? OP_INT16_TO_FP : OP_INT32_TO_FP,
                       random_fp(), random_fp(), random_int());
        end
        end_test("integer conversion");

        run_single(OP_FXTRACT, make_zero(1'b0), '0, '0);
        run_single(OP_FXTRACT, make_zero(1'b1), '0, '0);
        run_single(OP_FXTRACT, make_inf(1'b0), '0, '0);
        run_single(OP_FXTRACT, make_inf(1'b1), '0, '0);
        run_single(OP_FXTRACT, A_NAN, '0, '0);
        run_single(OP_FXTRACT, A_DEN, '0, '0);
        for (int n = 0; n < 300; n++) begin
            run_single(OP_FXTRACT, random_fp(), random_fp(), random_int());
        end
        end_test("fxtract");

        run_single(OP_FSCALE, A_MID, make_inf(1'b1), '0);
        run_single(OP_FSCALE, A_MID, make_inf(1'b0), '0);
        run_single(OP_FSCALE, A_NAN, B_NAN, '0);
        run_single(OP_FSCALE, A_MID, B_NAN, '0);
        run_single(OP_FSCALE, A_MID, FRAC, '0);
        run_single(OP_FSCALE, A_MID, M_FRAC, '0);
        run_single(OP_FSCALE, A_MID, HUGE, '0);
        run_single(OP_FSCALE, A_MID, M_HUGE, '0);
        run_single(OP_FSCALE, A_HIGH, TEN, '0);
        run_single(OP_FSCALE, A_LOW, M_TEN, '0);
        run_single(OP_FSCALE, make_zero(1'b1), TEN, '0);
        run_single(OP_FSCALE, make_inf(1'b0), M_TEN, '0);
        run_single(OP_FSCALE, A_DEN, FRAC, '0);
        for (int n = 0; n < 500; n++) begin
            run_single(OP_FSCALE, random_fp(), random_fp(), random_int());
        end
        end_test("fscale");

        run_back_to_back(60);
        // Unknown code must not touch out
        held      = out;
        operation = op_e'(5'd9);
        operand_a = random_fp();
        int_in    = random_int();
        enable    = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        check_value("done on unknown code", 162'(done), '0);
        check_value("out on unknown code", out, held);
        @(negedge clk);
        check_value("done after unknown code", 162'(done), '0);
        end_test("back to back and unknown code");

        $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Hard stop if the sequence hangs
    initial begin
        #200000;
        $display("Simulation stopped by the watchdog before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: fp80_bitops.f
+incdir+include
hw/fp80_pkg.sv
hw/fp80_int_to_fp.sv
hw/fp80_extract.sv
hw/fp80_scale.sv
hw/fp80_result_stage.sv
hw/fp80_bitops_unit.sv
bench/fp80_bitops_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FP80 bit-op testbench with Verilator, runs it and exits nonzero unless it passes

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f fp80_bitops.f \
        --top-module fp80_bitops_tb -o fp80_bitops_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/fp80_bitops_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
